/* verilog/lv_core_pkg.sv */
// shared LV core widths and register map; CRC-8 is poly 0x07, init 0x00, MSB first, no final xor
`default_nettype none

package lv_core_pkg;

// ==========================================================
// widths and vector types
// ==========================================================
localparam int REG_AW    = 7;
localparam int REG_DW    = 8;
localparam int CRC_W     = 8;
localparam int FRAME_W   = 24;
localparam int BIT_CNT_W = 6;   // headroom so over-long frames are caught

typedef logic [REG_AW-1:0]        reg_addr_t;
typedef logic [REG_DW-1:0]        reg_data_t;
typedef logic [CRC_W-1:0]         crc_t;
typedef logic [FRAME_W-CRC_W-1:0] payload_t;    // wr/err, addr, data
typedef logic [FRAME_W-1:0]       frame_t;
typedef logic [BIT_CNT_W-1:0]     bit_cnt_t;

// ==========================================================
// register map
// ==========================================================
localparam reg_addr_t ADDR_MODE      = 7'h00;   // write only
localparam reg_addr_t ADDR_STATUS    = 7'h01;   // sticky, w1c
localparam reg_addr_t ADDR_STATE     = 7'h02;   // read only
localparam reg_addr_t ADDR_DEAD_TIME = 7'h03;   // cfg state only
localparam reg_addr_t ADDR_BGR_TRIM  = 7'h04;   // cfg state only

// mode register bits
localparam int MODE_CFG_BIT = 0;
localparam int MODE_NML_BIT = 1;
localparam int MODE_RST_BIT = 2;

// status bits 1..3 (uv, ov, dead time) force the fault state, spi error does not
localparam reg_data_t FAULT_MASK = 8'b0000_1110;

localparam crc_t CRC_POLY = 8'h07;

typedef enum logic [1:0] {
    ST_STANDBY = 2'd0,
    ST_CFG     = 2'd1,
    ST_NORMAL  = 2'd2,
    ST_FAULT   = 2'd3
} ctrl_state_t;

// bitwise CRC over the 16 bit payload
function automatic crc_t crc8(input payload_t data);
    crc_t crc;
    logic fb;
    crc = '0;
    for (int i = FRAME_W - CRC_W - 1; i >= 0; i--) begin
        fb  = crc[CRC_W-1] ^ data[i];
        crc = {crc[CRC_W-2:0], 1'b0};
        if (fb) begin
            crc = crc ^ CRC_POLY;
        end
    end
    return crc;
endfunction

endpackage

`default_nettype wire

/* verilog/reg_req_if.sv */
// register request bus; no back-pressure, the bank acks exactly one cycle after req rises
`timescale 1ns/10ps
`default_nettype none

interface reg_req_if
    import lv_core_pkg::*;
();

// ==========================================================
// request side, held stable until ack
// ==========================================================
logic      req;
logic      wr;
reg_addr_t addr;
reg_data_t wdata;

// response side, valid with ack only
logic      ack;
reg_data_t rdata;
logic      err;

modport master (output req, wr, addr, wdata, input ack, rdata, err);

modport slave (input req, wr, addr, wdata, output ack, rdata, err);

// encoder only watches the completed access
modport monitor (input req, wr, addr, wdata, ack, rdata, err);

endinterface

`default_nettype wire

/* verilog/spi_frame_decoder.sv */
// SPI mode 0 command slave; i_clk must be at least 8x sclk, anything but a 24 bit frame is an error
`timescale 1ns/10ps
`default_nettype none

module spi_frame_decoder
    import lv_core_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_spi_sclk,
    input  logic      i_spi_csb,
    input  logic      i_spi_mosi,
    reg_req_if.master bus,
    output logic      o_spi_err,
    output logic      o_load_err
);

logic [2:0] pin_s1;     // {sclk, csb, mosi}
logic [2:0] pin_s2;
logic       sclk_d;
logic       csb_d;
logic       sclk_rise;
logic       csb_rise;
logic       csb_fall;
logic       frame_ok;
logic       frame_bad;
frame_t     shift_q;
bit_cnt_t   bit_cnt;

// ==========================================================
// pin synchroniser and edge detect
// ==========================================================
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        pin_s1 <= 3'b010;   // csb idles high
        pin_s2 <= 3'b010;
        sclk_d <= 1'b0;
        csb_d  <= 1'b1;
    end else begin
        pin_s1 <= {i_spi_sclk, i_spi_csb, i_spi_mosi};
        pin_s2 <= pin_s1;
        sclk_d <= pin_s2[2];
        csb_d  <= pin_s2[1];
    end
end

assign sclk_rise = pin_s2[2] & ~sclk_d & ~pin_s2[1];
assign csb_rise  = pin_s2[1] & ~csb_d;
assign csb_fall  = ~pin_s2[1] & csb_d;

// ==========================================================
// shift in and count
// ==========================================================
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        bit_cnt <= '0;
    end else if (csb_fall) begin
        bit_cnt <= '0;
    end else if (sclk_rise && bit_cnt <= bit_cnt_t'(FRAME_W)) begin
        bit_cnt <= bit_cnt + 1'b1;  // stops one past a full frame
    end
end

always_ff @(posedge i_clk) begin
    if (sclk_rise) begin
        shift_q <= {shift_q[FRAME_W-2:0], pin_s2[0]};
    end
end

assign frame_ok = (bit_cnt == bit_cnt_t'(FRAME_W)) &&
                  (shift_q[CRC_W-1:0] == crc8(shift_q[FRAME_W-1:CRC_W]));

// request issue, held until the bank acks
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        bus.req   <= 1'b0;
        frame_bad <= 1'b0;
    end else begin
        frame_bad <= csb_rise & ~frame_ok;
        if (csb_rise && frame_ok) begin
            bus.req <= 1'b1;
        end else if (bus.ack) begin
            bus.req <= 1'b0;
        end
    end
end

always_ff @(posedge i_clk) begin
    if (csb_rise && frame_ok) begin
        bus.wr    <= shift_q[FRAME_W-1];
        bus.addr  <= shift_q[FRAME_W-2 -: REG_AW];
        bus.wdata <= shift_q[CRC_W +: REG_DW];
    end
end

assign o_spi_err  = frame_bad;  // to status bit 0
assign o_load_err = frame_bad;  // error response

a_req_hold : assert property (@(posedge i_clk) disable iff (i_reset)
    bus.req && !bus.ack |=> bus.req && $stable(bus.addr));

// next frame can never end before the previous access completes
a_no_overrun : assert property (@(posedge i_clk) disable iff (i_reset)
    csb_rise |-> !bus.req);

endmodule

`default_nettype wire

/* verilog/lv_reg_bank.sv */
// LV register bank with a fixed one cycle ack; dead time and trim are writable only in ST_CFG
`timescale 1ns/10ps
`default_nettype none

module lv_reg_bank
    import lv_core_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    reg_req_if.slave    bus,
    input  logic        i_spi_err,
    input  logic        i_lv_vsup_uv,
    input  logic        i_lv_vsup_ov,
    input  logic        i_lv_pwm_dterr,
    input  ctrl_state_t i_state,
    output reg_data_t   o_status,
    output logic        o_cfg_req,
    output logic        o_nml_req,
    output logic        o_rst_req,
    output reg_data_t   o_dead_time,
    output reg_data_t   o_bgr_trim
);

logic [2:0] flt_s1;     // {dterr, ov, uv}
logic [2:0] flt_s2;
logic       req_q;
logic       req_new;
logic       cfg_st;
reg_data_t  sts_set;
reg_data_t  sts_clr;
reg_data_t  sts_nxt;
logic       mode_we;
logic       dt_we;
logic       trim_we;
logic       acc_err;
reg_data_t  acc_rdata;

assign req_new = bus.req & ~req_q;
assign cfg_st  = (i_state == ST_CFG);

// ==========================================================
// sticky status where a set wins over a clear in the same cycle
// ==========================================================
assign sts_set = {{(REG_DW-4){1'b0}}, flt_s2, i_spi_err};
assign sts_clr = (req_new && bus.wr && bus.addr == ADDR_STATUS) ? bus.wdata : '0;
assign sts_nxt = (o_status & ~sts_clr) | sts_set;

// ==========================================================
// access decode
// ==========================================================
always_comb begin
    acc_err   = 1'b0;
    acc_rdata = '0;
    mode_we   = 1'b0;
    dt_we     = 1'b0;
    trim_we   = 1'b0;
    case (bus.addr)
        ADDR_MODE: begin
            mode_we = bus.wr;
            acc_err = ~bus.wr;      // no read-back of mode
        end
        ADDR_STATUS: acc_rdata = sts_nxt;
        ADDR_STATE: begin
            acc_err   = bus.wr;
            acc_rdata = bus.wr ? '0 : {{(REG_DW-2){1'b0}}, i_state};
        end
        ADDR_DEAD_TIME: begin
            dt_we     = bus.wr & cfg_st;
            acc_err   = bus.wr & ~cfg_st;
            acc_rdata = dt_we ? bus.wdata : (bus.wr ? '0 : o_dead_time);
        end
        ADDR_BGR_TRIM: begin
            trim_we   = bus.wr & cfg_st;
            acc_err   = bus.wr & ~cfg_st;
            acc_rdata = trim_we ? bus.wdata : (bus.wr ? '0 : o_bgr_trim);
        end
        default: acc_err = 1'b1;    // unmapped
    endcase
end

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        flt_s1      <= '0;
        flt_s2      <= '0;
        req_q       <= 1'b0;
        bus.ack     <= 1'b0;
        o_status    <= '0;
        o_cfg_req   <= 1'b0;
        o_nml_req   <= 1'b0;
        o_rst_req   <= 1'b0;
        o_dead_time <= '0;
        o_bgr_trim  <= '0;
    end else begin
        flt_s1    <= {i_lv_pwm_dterr, i_lv_vsup_ov, i_lv_vsup_uv};
        flt_s2    <= flt_s1;
        req_q     <= bus.req;
        bus.ack   <= req_new;
        o_status  <= sts_nxt;
        o_cfg_req <= req_new & mode_we & bus.wdata[MODE_CFG_BIT];
        o_nml_req <= req_new & mode_we & bus.wdata[MODE_NML_BIT];
        o_rst_req <= req_new & mode_we & bus.wdata[MODE_RST_BIT];
        if (req_new && dt_we) begin
            o_dead_time <= bus.wdata;
        end
        if (req_new && trim_we) begin
            o_bgr_trim <= bus.wdata;
        end
    end
end

// response payload that the encoder samples with ack
always_ff @(posedge i_clk) begin
    if (req_new) begin
        bus.rdata <= acc_rdata;
        bus.err   <= acc_err;
    end
end

// req still held during the ack and released right after it
a_ack_timing : assert property (@(posedge i_clk) disable iff (i_reset)
    $rose(bus.req) |=> (bus.ack && bus.req) ##1 (!bus.ack && !bus.req));

endmodule

`default_nettype wire

/* verilog/lv_ctrl_fsm.sv */
// operating state control; any masked status bit forces ST_FAULT and only a clean status leaves it
`timescale 1ns/10ps
`default_nettype none

module lv_ctrl_fsm
    import lv_core_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  reg_data_t   i_status,
    input  logic        i_cfg_req,
    input  logic        i_nml_req,
    input  logic        i_rst_req,
    output ctrl_state_t o_state,
    output logic        o_pwm_en,
    output logic        o_intb_n
);

ctrl_state_t state_q;
ctrl_state_t state_nxt;
logic        fault;

assign fault = |(i_status & FAULT_MASK);

// ==========================================================
// next state
// ==========================================================
always_comb begin
    state_nxt = state_q;
    if (fault) begin
        state_nxt = ST_FAULT;   // overrides any mode request
    end else begin
        case (state_q)
            ST_STANDBY: if (i_cfg_req) state_nxt = ST_CFG;
            ST_CFG: begin
                if (i_rst_req) begin
                    state_nxt = ST_STANDBY;
                end else if (i_nml_req) begin
                    state_nxt = ST_NORMAL;
                end
            end
            ST_NORMAL: if (i_rst_req) state_nxt = ST_STANDBY;
            ST_FAULT:  if (i_rst_req) state_nxt = ST_STANDBY;
            default:   state_nxt = ST_STANDBY;
        endcase
    end
end

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        state_q  <= ST_STANDBY;
        o_pwm_en <= 1'b0;
        o_intb_n <= 1'b1;
    end else begin
        state_q  <= state_nxt;
        o_pwm_en <= (state_q == ST_NORMAL) & ~fault;    // drop at once on a fault
        o_intb_n <= ~|i_status;
    end
end

assign o_state = state_q;

// pwm only comes up straight after configuration
a_pwm_after_cfg : assert property (@(posedge i_clk) disable iff (i_reset)
    $rose(o_pwm_en) |-> $past(state_q, 2) == ST_CFG);

endmodule

`default_nettype wire

/* verilog/spi_response_encoder.sv */
// MISO driver; response is for the previous frame, first one after reset is all zeros
`timescale 1ns/10ps
`default_nettype none

module spi_response_encoder
    import lv_core_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    reg_req_if.monitor bus,
    input  logic       i_load_err,
    input  logic       i_spi_sclk,
    input  logic       i_spi_csb,
    output logic       o_spi_miso
);

logic [1:0] pin_s1;     // {sclk, csb}
logic [1:0] pin_s2;
logic       sclk_d;
logic       csb_d;
logic       sclk_fall;
logic       csb_fall;
payload_t   resp_hdr;
frame_t     resp_q;
frame_t     shift_q;

// err flag set, addr and data zero for a rejected frame
assign resp_hdr = bus.ack ? {bus.err, bus.addr, bus.rdata}
                          : {1'b1, {REG_AW{1'b0}}, {REG_DW{1'b0}}};

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        pin_s1 <= 2'b01;
        pin_s2 <= 2'b01;
        sclk_d <= 1'b0;
        csb_d  <= 1'b1;
        resp_q <= '0;
    end else begin
        pin_s1 <= {i_spi_sclk, i_spi_csb};
        pin_s2 <= pin_s1;
        sclk_d <= pin_s2[1];
        csb_d  <= pin_s2[0];
        if (bus.ack || i_load_err) begin
            resp_q <= {resp_hdr, crc8(resp_hdr)};
        end
    end
end

assign sclk_fall = ~pin_s2[1] & sclk_d;
assign csb_fall  = ~pin_s2[0] & csb_d;

// ==========================================================
// shift out MSB first
// ==========================================================
always_ff @(posedge i_clk) begin
    if (csb_fall) begin
        shift_q <= resp_q;
    end else if (sclk_fall && !csb_d) begin
        shift_q <= {shift_q[FRAME_W-2:0], 1'b0};
    end
end

assign o_spi_miso = shift_q[FRAME_W-1] & ~csb_d;   // low while deselected

endmodule

`default_nettype wire

/* verilog/lv_core.sv */
// LV core top; SPI pins are asynchronous to i_clk, which must run at least 8x sclk
`timescale 1ns/10ps
`default_nettype none

module lv_core
    import lv_core_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_spi_sclk,
    input  logic      i_spi_csb,
    input  logic      i_spi_mosi,
    input  logic      i_lv_vsup_uv,
    input  logic      i_lv_vsup_ov,
    input  logic      i_lv_pwm_dterr,
    output logic      o_spi_miso,
    output logic      o_pwm_en,
    output logic      o_intb_n,
    output reg_data_t o_dead_time,
    output reg_data_t o_bgr_trim
);

// ==========================================================
// internal wiring
// ==========================================================
logic        spi_err;
logic        load_err;
reg_data_t   status;
logic        cfg_req;
logic        nml_req;
logic        rst_req;
ctrl_state_t state;

reg_req_if req_bus ();

spi_frame_decoder spi_frame_decoder_inst (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_spi_sclk (i_spi_sclk),
    .i_spi_csb  (i_spi_csb),
    .i_spi_mosi (i_spi_mosi),
    .bus        (req_bus.master),
    .o_spi_err  (spi_err),
    .o_load_err (load_err)
);

lv_reg_bank lv_reg_bank_inst (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .bus            (req_bus.slave),
    .i_spi_err      (spi_err),
    .i_lv_vsup_uv   (i_lv_vsup_uv),
    .i_lv_vsup_ov   (i_lv_vsup_ov),
    .i_lv_pwm_dterr (i_lv_pwm_dterr),
    .i_state        (state),
    .o_status       (status),
    .o_cfg_req      (cfg_req),
    .o_nml_req      (nml_req),
    .o_rst_req      (rst_req),
    .o_dead_time    (o_dead_time),
    .o_bgr_trim     (o_bgr_trim)
);

lv_ctrl_fsm lv_ctrl_fsm_inst (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_status  (status),
    .i_cfg_req (cfg_req),
    .i_nml_req (nml_req),
    .i_rst_req (rst_req),
    .o_state   (state),
    .o_pwm_en  (o_pwm_en),
    .o_intb_n  (o_intb_n)
);

spi_response_encoder spi_response_encoder_inst (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .bus        (req_bus.monitor),
    .i_load_err (load_err),
    .i_spi_sclk (i_spi_sclk),
    .i_spi_csb  (i_spi_csb),
    .o_spi_miso (o_spi_miso)
);

endmodule

`default_nettype wire

/* sim/tb_lv_core_model.svh */
// reference model of the LV core, included inside tb_lv_core; mode writes carry one request bit
`ifndef TB_LV_CORE_MODEL_SVH
`define TB_LV_CORE_MODEL_SVH

ctrl_state_t m_state;
reg_data_t   m_status;
reg_data_t   m_dead_time;
reg_data_t   m_trim;
logic        m_uv;

// ============================================================
// CRC and frame building
// ============================================================
// polynomial long division of the payload shifted up by 8, divisor x^8+x^2+x+1
function automatic crc_t long_div_crc(input payload_t word);
    logic [FRAME_W-1:0] rem;
    rem = {word, 8'h00};
    for (int b = FRAME_W - 1; b >= CRC_W; b--) begin
        if (rem[b]) begin
            rem[b -: 9] = rem[b -: 9] ^ 9'h107;
        end
    end
    return rem[CRC_W-1:0];
endfunction

function automatic frame_t build_command(input logic wr, input reg_addr_t addr,
                                         input reg_data_t data);
    return {wr, addr, data, long_div_crc({wr, addr, data})};
endfunction

task automatic clear_model();
    m_state     = ST_STANDBY;
    m_status    = '0;
    m_dead_time = '0;
    m_trim      = '0;
    m_uv        = 1'b0;
    exp_q.push_back('0);    // first response after reset
endtask

task automatic note_undervoltage(input logic level);
    m_uv = level;
    if (level) begin
        m_status[1] = 1'b1;
        m_state     = ST_FAULT;
    end
endtask

function automatic void apply_mode(input reg_data_t data);
    if (|(m_status & FAULT_MASK)) begin
        m_state = ST_FAULT;
    end else begin
        case (m_state)
            ST_STANDBY: if (data[0]) m_state = ST_CFG;
            ST_CFG: begin
                if (data[2]) begin
                    m_state = ST_STANDBY;
                end else if (data[1]) begin
                    m_state = ST_NORMAL;
                end
            end
            ST_NORMAL: if (data[2]) m_state = ST_STANDBY;
            ST_FAULT:  if (data[2]) m_state = ST_STANDBY;
        endcase
    end
endfunction

// ============================================================
// expected responses
// ============================================================
function automatic frame_t predict_access(input logic wr, input reg_addr_t addr,
                                          input reg_data_t data);
    logic      err;
    reg_data_t rd;
    err = 1'b0;
    rd  = '0;
    case (addr)
        ADDR_MODE: begin
            err = ~wr;
            if (wr) begin
                apply_mode(data);
            end
        end
        ADDR_STATUS: begin
            if (wr) begin
                m_status = m_status & ~data;
            end
            m_status[1] = m_status[1] | m_uv;   // input still high sets it again
            rd = m_status;
        end
        ADDR_STATE: begin
            err = wr;
            rd  = wr ? 8'h00 : {6'b0, m_state};
        end
        ADDR_DEAD_TIME: begin
            err = wr && m_state != ST_CFG;
            if (wr && !err) begin
                m_dead_time = data;
            end
            rd = err ? 8'h00 : m_dead_time;
        end
        ADDR_BGR_TRIM: begin
            err = wr && m_state != ST_CFG;
            if (wr && !err) begin
                m_trim = data;
            end
            rd = err ? 8'h00 : m_trim;
        end
        default: err = 1'b1;
    endcase
    return build_command(err, addr, rd);
endfunction

function automatic frame_t reject_response();
    m_status[0] = 1'b1;     // spi error, sticky
    return build_command(1'b1, 7'h00, 8'h00);
endfunction

// ============================================================
// compare tasks
// ============================================================
task automatic check_word(input frame_t got, input frame_t want, inout int errs);
    if (got !== want) begin
        $display("ERROR @ %0t: response %06h, expected %06h", $time, got, want);
        errs++;
    end
endtask

task automatic check_data(input string what, input reg_data_t got, input reg_data_t want,
                          inout int errs);
    if (got !== want) begin
        $display("ERROR @ %0t: %s is %02h, expected %02h", $time, what, got, want);
        errs++;
    end
endtask

task automatic check_state(input ctrl_state_t got, input ctrl_state_t want, inout int errs);
    if (got !== want) begin
        $display("ERROR @ %0t: state reads %0d, expected %0d", $time, got, want);
        errs++;
    end
endtask

task automatic check_flag(input string what, input logic got, input logic want,
                          inout int errs);
    if (got !== want) begin
        $display("ERROR @ %0t: %s is %b, expected %b", $time, what, got, want);
        errs++;
    end
endtask

`endif

/* sim/tb_lv_core.sv */
// SPI master at 8 clocks per bit; a response is checked one frame after its command
`timescale 1ns/10ps
`default_nettype none

module tb_lv_core
    import lv_core_pkg::*;
();

localparam int N_FRAMES    = 80;    // upper bound over all tests
localparam int BIT_NS      = 800;
localparam int WATCHDOG_NS = N_FRAMES * FRAME_W * BIT_NS * 2 + 10_000;

logic      clk;
logic      reset;
logic      spi_sclk;
logic      spi_csb;
logic      spi_mosi;
logic      vsup_uv;
logic      vsup_ov;
logic      pwm_dterr;
logic      spi_miso;
logic      pwm_en;
logic      intb_n;
reg_data_t dead_time;
reg_data_t bgr_trim;

frame_t got_q[$];   // captured MISO words
frame_t exp_q[$];   // expected words in the same order
int     n_resp  = 0;
int     err_cmp = 0;
int     err_main;
int     err_mark;
int     n_tests;
int     n_failed;
int     seed;
logic [31:0] rnd;

`include "tb_lv_core_model.svh"

lv_core lv_core_inst (
    .i_clk          (clk),
    .i_reset        (reset),
    .i_spi_sclk     (spi_sclk),
    .i_spi_csb      (spi_csb),
    .i_spi_mosi     (spi_mosi),
    .i_lv_vsup_uv   (vsup_uv),
    .i_lv_vsup_ov   (vsup_ov),
    .i_lv_pwm_dterr (pwm_dterr),
    .o_spi_miso     (spi_miso),
    .o_pwm_en       (pwm_en),
    .o_intb_n       (intb_n),
    .o_dead_time    (dead_time),
    .o_bgr_trim     (bgr_trim)
);

always #50 clk = ~clk;

task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1;
endtask

// ============================================================
// SPI driver
// ============================================================
task automatic send_frame(input frame_t cmd);
    frame_t rx;
    rx      = '0;
    spi_csb = 1'b0;
    step(4);
    for (int i = FRAME_W - 1; i >= 0; i--) begin
        spi_mosi = cmd[i];
        step(4);
        rx[i]    = spi_miso;    // mode 0, sampled at the rising edge
        spi_sclk = 1'b1;
        step(4);
        spi_sclk = 1'b0;
    end
    step(4);
    spi_csb = 1'b1;
    step(8);    // ack comes 4 cycles after csb
    got_q.push_back(rx);
endtask

task automatic check_outputs();
    check_flag("o_pwm_en", pwm_en, m_state == ST_NORMAL, err_main);
    check_flag("o_intb_n", intb_n, m_status == 8'h00, err_main);
    check_data("o_dead_time", dead_time, m_dead_time, err_main);
    check_data("o_bgr_trim", bgr_trim, m_trim, err_main);
endtask

task automatic command(input logic wr, input reg_addr_t addr, input reg_data_t data);
    frame_t want;
    want = predict_access(wr, addr, data);
    send_frame(build_command(wr, addr, data));
    exp_q.push_back(want);
    check_outputs();
endtask

task automatic bad_frame(input reg_addr_t addr, input reg_data_t data);
    frame_t want;
    want = reject_response();
    send_frame(build_command(1'b1, addr, data) ^ frame_t'(1));  // corrupt crc
    exp_q.push_back(want);
    check_outputs();
endtask

task automatic drive_uv(input logic level);
    vsup_uv = level;
    note_undervoltage(level);
endtask

task automatic wait_pwm(input logic level);
    int n;
    n = 0;
    while (pwm_en !== level && n < 20) begin
        step(1);
        n++;
    end
    if (pwm_en !== level) begin
        $display("o_pwm_en did not go to %b within 20 clock cycles", level);
        err_main++;
    end
endtask

task automatic open_test();
    err_mark = err_main + err_cmp;
endtask

task automatic close_test(input string name);
    int errs;
    command(1'b0, ADDR_STATE, 8'h00);   // flush, brings out the last response
    step(2);
    errs = err_main + err_cmp - err_mark;
    n_tests++;
    if (errs == 0) begin
        $display("test %0d %s: ok", n_tests, name);
    end else begin
        n_failed++;
        $display("test %0d %s: %0d errors", n_tests, name, errs);
    end
endtask

// compare process
always @(posedge clk) begin
    if (got_q.size() > n_resp) begin
        check_word(got_q[n_resp], exp_q[n_resp], err_cmp);
        if (exp_q[n_resp][FRAME_W-2 -: REG_AW] == ADDR_STATE && !exp_q[n_resp][FRAME_W-1]) begin
            check_state(ctrl_state_t'(got_q[n_resp][CRC_W +: 2]),
                        ctrl_state_t'(exp_q[n_resp][CRC_W +: 2]), err_cmp);
        end
        n_resp++;
    end
end

// ============================================================
// test sequence
// ============================================================
initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    spi_sclk  = 1'b0;
    spi_csb   = 1'b1;
    spi_mosi  = 1'b0;
    vsup_uv   = 1'b0;
    vsup_ov   = 1'b0;
    pwm_dterr = 1'b0;
    seed      = 92;
    err_main  = 0;
    n_tests   = 0;
    n_failed  = 0;
    clear_model();
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    step(4);

    open_test();
    command(1'b1, ADDR_MODE, 8'h01);
    command(1'b1, ADDR_DEAD_TIME, 8'h3C);
    command(1'b1, ADDR_BGR_TRIM, 8'hA5);
    command(1'b0, ADDR_DEAD_TIME, 8'h00);
    command(1'b0, ADDR_BGR_TRIM, 8'h00);
    command(1'b1, ADDR_MODE, 8'h04);
    close_test("config writes and read-back");

    open_test();
    command(1'b1, ADDR_DEAD_TIME, 8'h55);   // rejected outside cfg
    command(1'b0, 7'h55, 8'h00);
    command(1'b0, ADDR_DEAD_TIME, 8'h00);
    close_test("access errors in standby");

    open_test();
    bad_frame(ADDR_DEAD_TIME, 8'h11);
    command(1'b0, ADDR_STATUS, 8'h00);
    command(1'b1, ADDR_STATUS, 8'h01);
    command(1'b0, ADDR_STATE, 8'h00);
    close_test("bad crc and status clear");

    open_test();
    command(1'b1, ADDR_MODE, 8'h01);
    command(1'b0, ADDR_STATE, 8'h00);
    command(1'b1, ADDR_MODE, 8'h02);
    command(1'b0, ADDR_STATE, 8'h00);
    command(1'b1, ADDR_MODE, 8'h04);
    command(1'b0, ADDR_STATE, 8'h00);
    close_test("mode sequencing");

    open_test();
    command(1'b1, ADDR_MODE, 8'h01);
    command(1'b1, ADDR_MODE, 8'h02);
    drive_uv(1'b1);
    wait_pwm(1'b0);
    check_outputs();
    command(1'b0, ADDR_STATE, 8'h00);
    command(1'b0, ADDR_STATUS, 8'h00);
    command(1'b1, ADDR_MODE, 8'h04);        // refused, fault still present
    command(1'b0, ADDR_STATE, 8'h00);
    drive_uv(1'b0);
    command(1'b1, ADDR_STATUS, 8'h02);
    command(1'b1, ADDR_MODE, 8'h04);
    command(1'b0, ADDR_STATE, 8'h00);
    close_test("undervoltage fault and recovery");

    open_test();
    command(1'b1, ADDR_MODE, 8'h01);
    for (int k = 0; k < 40; k++) begin
        rnd = $random(seed);
        command(rnd[0], ADDR_BGR_TRIM, rnd[15:8]);
    end
    command(1'b1, ADDR_MODE, 8'h04);
    close_test("random trim access");

    step(2);
    if (n_resp == 0 || got_q.size() != n_resp) begin
        $display("not every captured response was compared");
        err_main++;
    end
    $display("%0d tests, %0d failed, %0d responses checked, %0d errors",
             n_tests, n_failed, n_resp, err_main + err_cmp);
    if (err_main + err_cmp == 0) begin
        $display("TEST RESULT: PASS");
    end else begin
        $display("TEST RESULT: FAIL");
    end
    $finish;
end

initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
end

endmodule

`default_nettype wire

/* project.f */
+incdir+sim
verilog/lv_core_pkg.sv
verilog/reg_req_if.sv
verilog/spi_frame_decoder.sv
verilog/lv_reg_bank.sv
verilog/lv_ctrl_fsm.sv
verilog/spi_response_encoder.sv
verilog/lv_core.sv
sim/tb_lv_core.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the LV core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f project.f --top-module tb_lv_core -o tb_lv_core

out=$(./obj_dir/tb_lv_core)
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi
